// ==== compile.f ====
+incdir+tb
verilog/parking_id_pkg.sv
verilog/parking_ctrl_pkg.sv
verilog/second_ticker.sv
verilog/id_entry.sv
verilog/id_checker.sv
verilog/space_allocator.sv
verilog/gate_controller.sv
verilog/parking_top.sv
tb/parking_tb.sv

// ==== tb/parking_ref.svh ====
`ifndef PARKING_REF_SVH
`define PARKING_REF_SVH

typedef struct packed {
    parking_ctrl_pkg::verdict_t verdict;
    parking_ctrl_pkg::floor_t   floor_no;
} outcome_t;

// Occupancy as the testbench tracks it
parking_ctrl_pkg::count_t model_special;
parking_ctrl_pkg::count_t model_norm0;
parking_ctrl_pkg::count_t model_floor1;

// Seven nibbles, first keyed digit on top
function automatic logic id_is_valid(input logic [27:0] id);
    logic ok;
    int i;
    ok = (id[27:24] != 4'd0);
    for (i = 0; i < 7; i++) begin
        if (id[4*i +: 4] > 4'd9) begin
            ok = 1'b0;
        end
    end
    return ok;
endfunction

function automatic outcome_t expected_outcome(
    input parking_ctrl_pkg::count_t special_left,
    input parking_ctrl_pkg::count_t norm0_left,
    input parking_ctrl_pkg::count_t floor1_left,
    input logic [27:0]              id,
    input parking_ctrl_pkg::floor_t flr_sel,
    input parking_ctrl_pkg::mode_t  mode_sel
);
    outcome_t result;
    logic special;
    parking_ctrl_pkg::count_t chosen_left;
    parking_ctrl_pkg::count_t other_left;
    parking_ctrl_pkg::count_t section_left;
    int section_cap;
    special = (id[27:24] == 4'd9);
    chosen_left = flr_sel ? floor1_left : norm0_left;
    other_left = flr_sel ? norm0_left : floor1_left;
    result.floor_no = flr_sel;
    if (!id_is_valid(id)) begin
        result.verdict = parking_ctrl_pkg::INCORRECT;
    end else if (mode_sel == parking_ctrl_pkg::EXIT) begin
        section_left = special ? special_left : chosen_left;
        section_cap = special ? SPECIAL_CAP : (flr_sel ? FLOOR1_CAP : NORM0_CAP);
        if (section_left == section_cap) begin
            result.verdict = parking_ctrl_pkg::INCORRECT;
        end else begin
            result.verdict = parking_ctrl_pkg::EXITED;
        end
    end else if (special) begin
        // Special section is on floor 0
        result.floor_no = 1'b0;
        if (special_left == 0) begin
            result.verdict = parking_ctrl_pkg::NO_SPACE;
        end else if (flr_sel) begin
            result.verdict = parking_ctrl_pkg::GRANTED_ALT;
        end else begin
            result.verdict = parking_ctrl_pkg::GRANTED_CHOSEN;
        end
    end else if (chosen_left != 0) begin
        result.verdict = parking_ctrl_pkg::GRANTED_CHOSEN;
    end else if (other_left != 0) begin
        result.verdict = parking_ctrl_pkg::GRANTED_ALT;
        result.floor_no = !flr_sel;
    end else begin
        result.verdict = parking_ctrl_pkg::NO_SPACE;
    end
    return result;
endfunction

task automatic apply_outcome(input outcome_t result, input logic special);
    if (result.verdict == parking_ctrl_pkg::GRANTED_CHOSEN ||
        result.verdict == parking_ctrl_pkg::GRANTED_ALT) begin
        if (special) begin
            model_special--;
        end else if (result.floor_no) begin
            model_floor1--;
        end else begin
            model_norm0--;
        end
    end else if (result.verdict == parking_ctrl_pkg::EXITED) begin
        if (special) begin
            model_special++;
        end else if (result.floor_no) begin
            model_floor1++;
        end else begin
            model_norm0++;
        end
    end
endtask

`endif

// ==== tb/parking_tb.sv ====
module parking_tb;

    localparam int TICK_CYCLES   = 4;
    localparam int INPUT_TIMEOUT = 5;
    localparam int HOLD_WRONG    = 5;
    localparam int HOLD_OK       = 3;
    localparam int SPECIAL_CAP   = 2;
    localparam int NORM0_CAP     = 4;
    localparam int FLOOR1_CAP    = 4;

    localparam int NUM_IDS       = 21;
    localparam int ACK_LIMIT     = 8;
    localparam int APPEAR_LIMIT  = 10;
    localparam int HOLD_LIMIT    = (HOLD_WRONG + 2) * TICK_CYCLES + 4;
    localparam int CYCLES_PER_ID = 7 * 4 + APPEAR_LIMIT + HOLD_LIMIT;
    localparam int EXTRA_CYCLES  = 4 + 20 + (INPUT_TIMEOUT + 2) * TICK_CYCLES + 3 * 4;
    localparam int MAX_CYCLES    = 2 * (NUM_IDS * CYCLES_PER_ID + EXTRA_CYCLES);

    `include "parking_ref.svh"

    logic clk = 1'b0;
    logic reset;
    logic power;
    parking_ctrl_pkg::mode_t    mode;
    parking_ctrl_pkg::floor_t   flr;
    logic key_req;
    parking_id_pkg::digit_t     key_digit;
    logic key_ack;
    parking_ctrl_pkg::verdict_t verdict;
    parking_ctrl_pkg::floor_t   granted_floor;
    logic red_power_led;
    logic red_wrong_led;
    logic green_led;
    parking_ctrl_pkg::count_t   remain_special;
    parking_ctrl_pkg::count_t   remain_norm0;
    parking_ctrl_pkg::count_t   remain_floor1;

    int seed = 79;
    int value_errors = 0;
    int other_errors = 0;
    int verdicts_seen = 0;
    int cycle_count = 0;
    logic expect_pending = 1'b0;
    logic counts_due = 1'b0;
    outcome_t exp_outcome;
    parking_ctrl_pkg::verdict_t prev_verdict = parking_ctrl_pkg::NONE;
    logic [27:0] partial_id;

    parking_top #(
        .TICK_CYCLES   (TICK_CYCLES),
        .INPUT_TIMEOUT (INPUT_TIMEOUT),
        .HOLD_WRONG    (HOLD_WRONG),
        .HOLD_OK       (HOLD_OK),
        .SPECIAL_CAP   (SPECIAL_CAP),
        .NORM0_CAP     (NORM0_CAP),
        .FLOOR1_CAP    (FLOOR1_CAP)
    ) parking_top_inst (
        .clk            (clk),
        .reset          (reset),
        .power          (power),
        .mode           (mode),
        .flr            (flr),
        .key_req        (key_req),
        .key_digit      (key_digit),
        .key_ack        (key_ack),
        .verdict        (verdict),
        .granted_floor  (granted_floor),
        .red_power_led  (red_power_led),
        .red_wrong_led  (red_wrong_led),
        .green_led      (green_led),
        .remain_special (remain_special),
        .remain_norm0   (remain_norm0),
        .remain_floor1  (remain_floor1)
    );

    always #20 clk = ~clk;

    task automatic check_verdict(input string name, input parking_ctrl_pkg::verdict_t exp,
                                 input parking_ctrl_pkg::verdict_t act);
        if (act !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_floor(input string name, input parking_ctrl_pkg::floor_t exp,
                               input parking_ctrl_pkg::floor_t act);
        if (act !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input parking_ctrl_pkg::count_t exp,
                               input parking_ctrl_pkg::count_t act);
        if (act !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    function automatic parking_id_pkg::digit_t normal_class();
        return 4'(1 + $unsigned($random(seed)) % 8);
    endfunction

    function automatic logic [27:0] make_id(input parking_id_pkg::digit_t class_digit);
        logic [27:0] id;
        int i;
        id[27:24] = class_digit;
        for (i = 0; i < 6; i++) begin
            id[4*i +: 4] = 4'($unsigned($random(seed)) % 10);
        end
        return id;
    endfunction

    task automatic expect_id(input logic [27:0] id);
        exp_outcome = expected_outcome(model_special, model_norm0, model_floor1, id, flr, mode);
        apply_outcome(exp_outcome, id[27:24] == 4'd9);
        expect_pending = 1'b1;
    endtask

    // Finish a handshake whose request is already up
    task automatic complete_digit();
        int waited;
        waited = 0;
        while (!key_ack && waited < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!key_ack) begin
            other_errors++;
            $display("No key_ack came for digit %h at %0t", key_digit, $time);
        end
        key_req = 1'b0;
        waited = 0;
        while (key_ack && waited < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (key_ack) begin
            other_errors++;
            $display("key_ack stayed high after key_req dropped at %0t", $time);
        end
    endtask

    task automatic send_digit(input parking_id_pkg::digit_t d);
        key_digit = d;
        key_req = 1'b1;
        complete_digit();
    endtask

    task automatic await_verdict();
        int waited;
        waited = 0;
        while (verdict == parking_ctrl_pkg::NONE && waited < APPEAR_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (verdict == parking_ctrl_pkg::NONE) begin
            other_errors++;
            $display("No verdict appeared after a full ID at %0t", $time);
        end else begin
            waited = 0;
            while (verdict != parking_ctrl_pkg::NONE && waited < HOLD_LIMIT) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (verdict != parking_ctrl_pkg::NONE) begin
                other_errors++;
                $display("Verdict never returned to NONE at %0t", $time);
            end
        end
        expect_pending = 1'b0;
    endtask

    task automatic run_id(input logic [27:0] id, input parking_ctrl_pkg::floor_t f,
                          input parking_ctrl_pkg::mode_t m);
        int i;
        flr = f;
        mode = m;
        expect_id(id);
        for (i = 6; i >= 0; i--) begin
            send_digit(id[4*i +: 4]);
        end
        await_verdict();
    endtask

    // Counts settle one cycle after the verdict
    always @(negedge clk) begin
        if (counts_due) begin
            check_count("remain_special", model_special, remain_special);
            check_count("remain_norm0", model_norm0, remain_norm0);
            check_count("remain_floor1", model_floor1, remain_floor1);
            counts_due = 1'b0;
        end
        if (!reset && verdict !== parking_ctrl_pkg::NONE && prev_verdict === parking_ctrl_pkg::NONE) begin
            if (!expect_pending) begin
                other_errors++;
                $display("A verdict appeared with no ID pending at %0t", $time);
            end else begin
                check_verdict("verdict", exp_outcome.verdict, verdict);
                if (exp_outcome.verdict == parking_ctrl_pkg::GRANTED_CHOSEN ||
                    exp_outcome.verdict == parking_ctrl_pkg::GRANTED_ALT) begin
                    check_floor("granted_floor", exp_outcome.floor_no, granted_floor);
                end
                check_bit("green_led", exp_outcome.verdict == parking_ctrl_pkg::GRANTED_CHOSEN ||
                          exp_outcome.verdict == parking_ctrl_pkg::GRANTED_ALT ||
                          exp_outcome.verdict == parking_ctrl_pkg::EXITED, green_led);
                check_bit("red_wrong_led", exp_outcome.verdict == parking_ctrl_pkg::INCORRECT ||
                          exp_outcome.verdict == parking_ctrl_pkg::NO_SPACE, red_wrong_led);
                check_bit("red_power_led", 1'b1, red_power_led);
                expect_pending = 1'b0;
                counts_due = 1'b1;
                verdicts_seen++;
            end
        end
        prev_verdict = verdict;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Run stopped at the cycle limit of %0d", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        power = 1'b0;
        mode = parking_ctrl_pkg::ENTER;
        flr = 1'b0;
        key_req = 1'b0;
        key_digit = 4'd0;
        model_special = SPECIAL_CAP;
        model_norm0 = NORM0_CAP;
        model_floor1 = FLOOR1_CAP;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        @(posedge clk);
        #1;
        check_bit("red_power_led", 1'b0, red_power_led);
        check_bit("red_wrong_led", 1'b0, red_wrong_led);
        check_bit("green_led", 1'b0, green_led);
        check_verdict("verdict", parking_ctrl_pkg::NONE, verdict);
        check_count("remain_special", SPECIAL_CAP, remain_special);
        check_count("remain_norm0", NORM0_CAP, remain_norm0);
        check_count("remain_floor1", FLOOR1_CAP, remain_floor1);

        // Request held while power is low
        expect_id(28'h1234567);
        key_digit = 4'd1;
        key_req = 1'b1;
        repeat (20) begin
            @(posedge clk);
            #1;
            check_bit("key_ack", 1'b0, key_ack);
        end
        power = 1'b1;
        @(posedge clk);
        #1;
        check_bit("red_power_led", 1'b1, red_power_led);
        complete_digit();
        for (int i = 5; i >= 0; i--) begin
            send_digit(4'(i == 5 ? 2 : 7 - i));
        end
        await_verdict();

        run_id(make_id(normal_class()), 1'b1, parking_ctrl_pkg::ENTER);
        run_id(make_id(normal_class()), 1'b1, parking_ctrl_pkg::ENTER);
        run_id(make_id(normal_class()), 1'b0, parking_ctrl_pkg::ENTER);

        // Floor 0 fills, then floor 1, then nothing is left
        repeat (5) run_id(make_id(normal_class()), 1'b0, parking_ctrl_pkg::ENTER);
        run_id(make_id(normal_class()), 1'b1, parking_ctrl_pkg::ENTER);

        run_id(make_id(4'd9), 1'b0, parking_ctrl_pkg::ENTER);
        run_id(make_id(4'd9), 1'b1, parking_ctrl_pkg::ENTER);
        run_id(make_id(4'd9), 1'b0, parking_ctrl_pkg::ENTER);
        partial_id = make_id(normal_class());
        partial_id[11:8] = 4'hc;
        run_id(partial_id, 1'b0, parking_ctrl_pkg::ENTER);
        run_id(make_id(4'd0), 1'b1, parking_ctrl_pkg::ENTER);

        run_id(make_id(normal_class()), 1'b0, parking_ctrl_pkg::EXIT);
        repeat (3) run_id(make_id(4'd9), 1'b0, parking_ctrl_pkg::EXIT);
        run_id(make_id(normal_class()), 1'b1, parking_ctrl_pkg::EXIT);

        // Partial ID left to time out
        partial_id = make_id(normal_class());
        send_digit(partial_id[27:24]);
        send_digit(partial_id[23:20]);
        send_digit(partial_id[19:16]);
        repeat ((INPUT_TIMEOUT + 2) * TICK_CYCLES) @(posedge clk);
        #1;
        run_id(make_id(normal_class()), 1'b0, parking_ctrl_pkg::ENTER);

        repeat (2) @(posedge clk);
        if (verdicts_seen != NUM_IDS) begin
            other_errors++;
            $display("Saw %0d verdicts for %0d IDs sent", verdicts_seen, NUM_IDS);
        end
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/gate_controller.sv ====
module gate_controller #(
    parameter int INPUT_TIMEOUT = 5,
    parameter int HOLD_WRONG    = 5,
    parameter int HOLD_OK       = 3
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       power,
    input  logic                       digit_taken,
    input  logic                       check_done,
    input  logic                       id_valid,
    input  parking_ctrl_pkg::verdict_t decision,
    input  parking_ctrl_pkg::floor_t   decided_floor,
    input  parking_ctrl_pkg::sec_t     seconds,
    output logic                       accept,
    output logic                       clear_id,
    output logic                       clear_sec,
    output logic                       commit,
    output parking_ctrl_pkg::verdict_t verdict,
    output parking_ctrl_pkg::floor_t   granted_floor,
    output logic                       red_power_led,
    output logic                       red_wrong_led,
    output logic                       green_led
);

    typedef enum logic [1:0] {
        OFF,
        IDLE,
        INPUTTING,
        SHOW
    } state_t;

    state_t state;
    parking_ctrl_pkg::sec_t hold_limit;
    logic input_expired;
    logic hold_expired;
    logic wrong_verdict;
    logic good_verdict;

    // No timeout while a digit or a check result is arriving
    assign input_expired = (state == INPUTTING) && !digit_taken && !check_done &&
                           (seconds >= parking_ctrl_pkg::sec_t'(INPUT_TIMEOUT));

    assign hold_limit = (verdict == parking_ctrl_pkg::INCORRECT) ?
                        parking_ctrl_pkg::sec_t'(HOLD_WRONG) : parking_ctrl_pkg::sec_t'(HOLD_OK);
    assign hold_expired = (state == SHOW) && (seconds >= hold_limit);

    assign accept    = power && (state == IDLE || state == INPUTTING);
    assign clear_id  = !power || (state == OFF) || input_expired || hold_expired;
    assign clear_sec = (state == OFF) || (state == IDLE) || digit_taken || check_done;

    assign wrong_verdict = verdict inside {parking_ctrl_pkg::INCORRECT, parking_ctrl_pkg::NO_SPACE};
    assign good_verdict  = verdict inside {parking_ctrl_pkg::GRANTED_CHOSEN,
                                           parking_ctrl_pkg::GRANTED_ALT,
                                           parking_ctrl_pkg::EXITED};

    assign red_power_led = (state != OFF);
    assign red_wrong_led = (state == SHOW) && wrong_verdict;
    assign green_led     = (state == SHOW) && good_verdict;

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= OFF;
            verdict       <= parking_ctrl_pkg::NONE;
            granted_floor <= 1'b0;
            commit        <= 1'b0;
        end else begin
            commit <= 1'b0;
            if (!power) begin
                state   <= OFF;
                verdict <= parking_ctrl_pkg::NONE;
            end else begin
                case (state)
                    OFF: state <= IDLE;
                    IDLE: begin
                        if (digit_taken) begin
                            state <= INPUTTING;
                        end
                    end
                    INPUTTING: begin
                        if (check_done) begin
                            state         <= SHOW;
                            commit        <= id_valid;
                            granted_floor <= decided_floor;
                            if (id_valid) begin
                                verdict <= decision;
                            end else begin
                                verdict <= parking_ctrl_pkg::INCORRECT;
                            end
                        end else if (input_expired) begin
                            state <= IDLE;
                        end
                    end
                    SHOW: begin
                        if (hold_expired) begin
                            state   <= IDLE;
                            verdict <= parking_ctrl_pkg::NONE;
                        end
                    end
                    default: state <= OFF;
                endcase
            end
        end
    end

endmodule

// ==== verilog/id_checker.sv ====
module id_checker (
    input  logic                     clk,
    input  logic                     reset,
    input  parking_id_pkg::id_word_t id_word,
    input  logic                     id_full,
    output logic                     check_done,
    output logic                     id_valid,
    output logic                     id_special
);

    logic full_q;
    logic full_rise;
    logic digits_ok;

    assign full_rise = id_full && !full_q;

    always_comb begin
        digits_ok = 1'b1;
        for (int i = 0; i < parking_id_pkg::ID_DIGITS; i++) begin
            if (id_word.digits[i] > 4'd9) begin
                digits_ok = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            full_q     <= 1'b0;
            check_done <= 1'b0;
            id_valid   <= 1'b0;
            id_special <= 1'b0;
        end else begin
            full_q     <= id_full;
            check_done <= full_rise;
            if (full_rise) begin
                // Leading zero is not a valid class
                id_valid   <= digits_ok && (id_word.digits[parking_id_pkg::ID_DIGITS-1] != 4'd0);
                id_special <= (id_word.fields.class_digit == parking_id_pkg::SPECIAL_CLASS);
            end
        end
    end

endmodule

// ==== verilog/id_entry.sv ====
module id_entry (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     accept,
    input  logic                     clear,
    input  logic                     key_req,
    input  parking_id_pkg::digit_t   key_digit,
    output logic                     key_ack,
    output logic                     digit_taken,
    output parking_id_pkg::id_word_t id_word,
    output logic                     id_full
);

    localparam int COUNT_W = $clog2(parking_id_pkg::ID_DIGITS + 1);

    logic [COUNT_W-1:0] digit_count;

    assign id_full = (digit_count == COUNT_W'(parking_id_pkg::ID_DIGITS));

    // New request seen while ack is still low
    assign digit_taken = accept && key_req && !key_ack && !id_full;

    // Four-phase responder
    always_ff @(posedge clk) begin
        if (reset) begin
            key_ack <= 1'b0;
        end else if (digit_taken) begin
            key_ack <= 1'b1;
        end else if (key_ack && !key_req) begin
            key_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            digit_count <= '0;
        end else if (digit_taken) begin
            digit_count <= digit_count + 1'b1;
        end
    end

    // Shift in from the low end so the first digit ends on top
    always_ff @(posedge clk) begin
        if (digit_taken) begin
            id_word <= {id_word.digits[parking_id_pkg::ID_DIGITS-2:0], key_digit};
        end
    end

endmodule

// ==== verilog/parking_ctrl_pkg.sv ====
package parking_ctrl_pkg;

    // Outcome shown to the driver
    typedef enum logic [2:0] {
        NONE,
        INCORRECT,
        GRANTED_CHOSEN,
        GRANTED_ALT,
        NO_SPACE,
        EXITED
    } verdict_t;

    // Floor 0 or 1
    typedef logic floor_t;

    // Remaining spaces of one section
    typedef logic [3:0] count_t;

    // Elapsed seconds, saturating
    typedef logic [3:0] sec_t;

    typedef enum logic {
        ENTER,
        EXIT
    } mode_t;

endpackage

// ==== verilog/parking_id_pkg.sv ====
package parking_id_pkg;

    // Digits per driver ID
    localparam int ID_DIGITS = 7;

    typedef logic [3:0] digit_t;

    // Class digit of a special ID
    localparam digit_t SPECIAL_CLASS = 4'd9;

    // First-keyed digit sits on top
    typedef struct packed {
        digit_t      class_digit;
        logic [23:0] serial;
    } id_fields_t;

    // Digit view for range checks, field view for classification
    typedef union packed {
        digit_t [ID_DIGITS-1:0] digits;
        id_fields_t             fields;
    } id_word_t;

endpackage

// ==== verilog/parking_top.sv ====
module parking_top #(
    parameter int TICK_CYCLES   = 50_000_000,
    parameter int INPUT_TIMEOUT = 5,
    parameter int HOLD_WRONG    = 5,
    parameter int HOLD_OK       = 3,
    parameter int SPECIAL_CAP   = 2,
    parameter int NORM0_CAP     = 4,
    parameter int FLOOR1_CAP    = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       power,
    input  parking_ctrl_pkg::mode_t    mode,
    input  parking_ctrl_pkg::floor_t   flr,
    input  logic                       key_req,
    input  parking_id_pkg::digit_t     key_digit,
    output logic                       key_ack,
    output parking_ctrl_pkg::verdict_t verdict,
    output parking_ctrl_pkg::floor_t   granted_floor,
    output logic                       red_power_led,
    output logic                       red_wrong_led,
    output logic                       green_led,
    output parking_ctrl_pkg::count_t   remain_special,
    output parking_ctrl_pkg::count_t   remain_norm0,
    output parking_ctrl_pkg::count_t   remain_floor1
);

    logic accept;
    logic clear_id;
    logic clear_sec;
    logic commit;
    logic digit_taken;
    logic id_full;
    logic check_done;
    logic id_valid;
    logic id_special;
    parking_id_pkg::id_word_t   id_word;
    parking_ctrl_pkg::sec_t     seconds;
    parking_ctrl_pkg::verdict_t decision;
    parking_ctrl_pkg::floor_t   decided_floor;

    second_ticker #(
        .TICK_CYCLES(TICK_CYCLES)
    ) second_ticker_inst (
        .clk     (clk),
        .reset   (reset),
        .clear   (clear_sec),
        .seconds (seconds)
    );

    id_entry id_entry_inst (
        .clk         (clk),
        .reset       (reset),
        .accept      (accept),
        .clear       (clear_id),
        .key_req     (key_req),
        .key_digit   (key_digit),
        .key_ack     (key_ack),
        .digit_taken (digit_taken),
        .id_word     (id_word),
        .id_full     (id_full)
    );

    id_checker id_checker_inst (
        .clk        (clk),
        .reset      (reset),
        .id_word    (id_word),
        .id_full    (id_full),
        .check_done (check_done),
        .id_valid   (id_valid),
        .id_special (id_special)
    );

    space_allocator #(
        .SPECIAL_CAP (SPECIAL_CAP),
        .NORM0_CAP   (NORM0_CAP),
        .FLOOR1_CAP  (FLOOR1_CAP)
    ) space_allocator_inst (
        .clk            (clk),
        .reset          (reset),
        .mode           (mode),
        .flr            (flr),
        .id_special     (id_special),
        .commit         (commit),
        .decision       (decision),
        .decided_floor  (decided_floor),
        .remain_special (remain_special),
        .remain_norm0   (remain_norm0),
        .remain_floor1  (remain_floor1)
    );

    gate_controller #(
        .INPUT_TIMEOUT (INPUT_TIMEOUT),
        .HOLD_WRONG    (HOLD_WRONG),
        .HOLD_OK       (HOLD_OK)
    ) gate_controller_inst (
        .clk           (clk),
        .reset         (reset),
        .power         (power),
        .digit_taken   (digit_taken),
        .check_done    (check_done),
        .id_valid      (id_valid),
        .decision      (decision),
        .decided_floor (decided_floor),
        .seconds       (seconds),
        .accept        (accept),
        .clear_id      (clear_id),
        .clear_sec     (clear_sec),
        .commit        (commit),
        .verdict       (verdict),
        .granted_floor (granted_floor),
        .red_power_led (red_power_led),
        .red_wrong_led (red_wrong_led),
        .green_led     (green_led)
    );

endmodule

// ==== verilog/second_ticker.sv ====
module second_ticker #(
    parameter int TICK_CYCLES = 50_000_000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clear,
    output parking_ctrl_pkg::sec_t seconds
);

    localparam int PRESCALE_W = $clog2(TICK_CYCLES + 1);

    logic [PRESCALE_W-1:0] prescale;
    logic                  tick;

    assign tick = (prescale == PRESCALE_W'(TICK_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            prescale <= '0;
            seconds  <= '0;
        end else begin
            if (tick) begin
                prescale <= '0;
            end else begin
                prescale <= prescale + 1'b1;
            end
            // Hold at the top value
            if (tick && seconds != '1) begin
                seconds <= seconds + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/space_allocator.sv ====
module space_allocator #(
    parameter int SPECIAL_CAP = 2,
    parameter int NORM0_CAP   = 4,
    parameter int FLOOR1_CAP  = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  parking_ctrl_pkg::mode_t     mode,
    input  parking_ctrl_pkg::floor_t    flr,
    input  logic                        id_special,
    input  logic                        commit,
    output parking_ctrl_pkg::verdict_t  decision,
    output parking_ctrl_pkg::floor_t    decided_floor,
    output parking_ctrl_pkg::count_t    remain_special,
    output parking_ctrl_pkg::count_t    remain_norm0,
    output parking_ctrl_pkg::count_t    remain_floor1
);

    parking_ctrl_pkg::count_t special_q;
    parking_ctrl_pkg::count_t norm0_q;
    parking_ctrl_pkg::count_t floor1_q;
    parking_ctrl_pkg::count_t step;
    logic chosen_free;
    logic other_free;
    logic section_full;
    logic changes_count;

    assign chosen_free = flr ? (floor1_q != '0) : (norm0_q != '0);
    assign other_free  = flr ? (norm0_q != '0) : (floor1_q != '0);

    // Exit section already back at capacity
    assign section_full = id_special ? (special_q == parking_ctrl_pkg::count_t'(SPECIAL_CAP)) :
                          flr        ? (floor1_q == parking_ctrl_pkg::count_t'(FLOOR1_CAP)) :
                                       (norm0_q == parking_ctrl_pkg::count_t'(NORM0_CAP));

    always_comb begin
        decided_floor = flr;
        if (mode == parking_ctrl_pkg::EXIT) begin
            decision = section_full ? parking_ctrl_pkg::INCORRECT : parking_ctrl_pkg::EXITED;
            if (id_special) begin
                decided_floor = 1'b0;
            end
        end else if (id_special) begin
            // Special section lives on floor 0
            if (special_q == '0) begin
                decision = parking_ctrl_pkg::NO_SPACE;
            end else begin
                decided_floor = 1'b0;
                decision = flr ? parking_ctrl_pkg::GRANTED_ALT : parking_ctrl_pkg::GRANTED_CHOSEN;
            end
        end else if (chosen_free) begin
            decision = parking_ctrl_pkg::GRANTED_CHOSEN;
        end else if (other_free) begin
            decision      = parking_ctrl_pkg::GRANTED_ALT;
            decided_floor = !flr;
        end else begin
            decision = parking_ctrl_pkg::NO_SPACE;
        end
    end

    assign changes_count = decision inside {parking_ctrl_pkg::GRANTED_CHOSEN,
                                            parking_ctrl_pkg::GRANTED_ALT,
                                            parking_ctrl_pkg::EXITED};

    // Plus one on exit, minus one on a grant
    assign step = (decision == parking_ctrl_pkg::EXITED) ? 4'd1 : 4'hf;

    always_ff @(posedge clk) begin
        if (reset) begin
            special_q <= parking_ctrl_pkg::count_t'(SPECIAL_CAP);
            norm0_q   <= parking_ctrl_pkg::count_t'(NORM0_CAP);
            floor1_q  <= parking_ctrl_pkg::count_t'(FLOOR1_CAP);
        end else if (commit && changes_count) begin
            if (id_special) begin
                special_q <= special_q + step;
            end else if (decided_floor) begin
                floor1_q <= floor1_q + step;
            end else begin
                norm0_q <= norm0_q + step;
            end
        end
    end

    assign remain_special = special_q;
    assign remain_norm0   = norm0_q;
    assign remain_floor1  = floor1_q;

endmodule
